// File: rtl/strand_select_defines.svh
// Strand select defines: instruction fields, class codes, NOP and hazard timing

`ifndef STRAND_SELECT_DEFINES_SVH
`define STRAND_SELECT_DEFINES_SVH

// Vector register lanes
`define NUM_LANES		16
`define LANE_BITS		4

// Instruction class field
`define OPCLASS_HI		31
`define OPCLASS_LO		29

`define CLASS_STRIDED	3'b111	// Strided load/store, one issue per lane
`define CLASS_LONG		3'b110	// Multi-cycle arithmetic

// Stride in bytes, zero extended
`define STRIDE_HI		9
`define STRIDE_LO		0

`define NOP				32'h0000_0000

// Single-cycle ops may not issue this many cycles after a long op
`define HAZARD_DISTANCE	3

`endif

// File: rtl/strand_select_pkg.sv
// Strand select package: shared vector types and strand controller states

`default_nettype none

`include "strand_select_defines.svh"

package strand_select_pkg;

	typedef logic [31:0] instr_t;
	typedef logic [31:0] pc_t;
	typedef logic [`LANE_BITS-1:0] lane_t;	// Register lane select
	typedef logic [31:0] offset_t;			// Strided byte offset
	typedef logic [1:0] strand_id_t;

	// Per-strand controller states
	typedef enum logic [1:0] {
		ST_ISSUE,		// Requesting issue while fetch is valid
		ST_FETCH_WAIT,	// One cycle for fetch to present the next instruction
		ST_SUSPENDED	// Waiting on a data cache miss
	} strand_state_t;

endpackage

`default_nettype wire

// File: rtl/strand_fsm.sv
// Strand controller: issue readiness, suspension, rollback and strided lane sequencing

`timescale 1ns/1ps
`default_nettype none

`include "strand_select_defines.svh"

module strand_fsm(
	input  logic							clk,
	input  logic							arst_n_i,
	input  strand_select_pkg::instr_t		instruction_i,
	input  logic							instruction_valid_i,
	input  strand_select_pkg::pc_t			pc_i,
	input  logic							grant_i,
	input  logic							flush_i,
	input  logic							suspend_strand_i,
	input  logic							resume_strand_i,
	input  strand_select_pkg::offset_t		rollback_strided_offset_i,
	input  strand_select_pkg::lane_t		rollback_reg_lane_i,
	output logic							issue_request_o,
	output logic							next_instruction_o,
	output strand_select_pkg::pc_t			pc_o,
	output strand_select_pkg::instr_t		instruction_o,
	output strand_select_pkg::lane_t		reg_lane_select_o,
	output strand_select_pkg::offset_t		strided_offset_o
);

	import strand_select_pkg::*;

	strand_state_t	state_q;
	lane_t			lane_q;
	offset_t		offset_q;
	offset_t		stride;
	logic			is_strided;
	logic			last_issue;
	logic			advance;

	assign is_strided = instruction_i[`OPCLASS_HI:`OPCLASS_LO] == `CLASS_STRIDED;
	assign stride = offset_t'(instruction_i[`STRIDE_HI:`STRIDE_LO]);
	assign last_issue = !is_strided || lane_q == '0;	// Lane 0 ends a strided op

	// A grant in the same cycle as a flush or suspend does not count
	assign advance = grant_i && !flush_i && !suspend_strand_i;

	assign issue_request_o = state_q == ST_ISSUE && instruction_valid_i;
	assign next_instruction_o = advance && last_issue;

	assign pc_o = pc_i;
	assign instruction_o = instruction_i;
	assign reg_lane_select_o = lane_q;
	assign strided_offset_o = offset_q;

	always_ff @(posedge clk or negedge arst_n_i)
	begin
		if (!arst_n_i)
		begin
			state_q <= ST_ISSUE;
			lane_q <= lane_t'(`NUM_LANES - 1);
			offset_q <= '0;
		end
		else if (flush_i)
		begin
			// Restart where the rollback unit says
			state_q <= ST_FETCH_WAIT;
			lane_q <= rollback_reg_lane_i;
			offset_q <= rollback_strided_offset_i;
		end
		else if (suspend_strand_i)
			state_q <= ST_SUSPENDED;
		else if (resume_strand_i && state_q == ST_SUSPENDED)
			state_q <= ST_ISSUE;	// Same instruction and lane as before
		else if (grant_i)
		begin
			if (last_issue)
			begin
				state_q <= ST_FETCH_WAIT;
				lane_q <= lane_t'(`NUM_LANES - 1);
				offset_q <= '0;
			end
			else
			begin
				lane_q <= lane_q - lane_t'(1);	// Next lane down
				offset_q <= offset_q + stride;
			end
		end
		else if (state_q == ST_FETCH_WAIT)
			state_q <= ST_ISSUE;
	end

endmodule

`default_nettype wire

// File: rtl/execute_hazard_detect.sv
// Writeback collision detector: blocks single-cycle ops behind a long-latency issue

`timescale 1ns/1ps
`default_nettype none

`include "strand_select_defines.svh"

module execute_hazard_detect(
	input  logic							clk,
	input  logic							arst_n_i,
	input  strand_select_pkg::instr_t		instruction_i [4],
	input  logic [3:0]						grant_i,
	output logic [3:0]						execute_hazard_o
);

	logic [`HAZARD_DISTANCE-1:0]	long_history_q;	// Bit n is the issue n+1 cycles ago
	logic [3:0]						is_long;
	logic							long_granted;

	always_comb
	begin
		for (int i = 0; i < 4; i++)
		begin
			is_long[i] = instruction_i[i][`OPCLASS_HI:`OPCLASS_LO] == `CLASS_LONG;
			execute_hazard_o[i] = long_history_q[`HAZARD_DISTANCE-1] && !is_long[i];
		end
	end

	assign long_granted = |(grant_i & is_long);

	always_ff @(posedge clk or negedge arst_n_i)
	begin
		if (!arst_n_i)
			long_history_q <= '0;
		else
			long_history_q <= {long_history_q[`HAZARD_DISTANCE-2:0], long_granted};
	end

endmodule

`default_nettype wire

// File: rtl/issue_arbiter.sv
// Issue arbiter: four-way rotating priority, the last winner drops to lowest

`timescale 1ns/1ps
`default_nettype none

module issue_arbiter(
	input  logic		clk,
	input  logic		arst_n_i,
	input  logic [3:0]	request_i,
	output logic [3:0]	grant_o
);

	import strand_select_pkg::*;

	strand_id_t	last_q;
	strand_id_t	cand;
	strand_id_t	winner;
	logic		found;

	// Search starts one past the last winner
	always_comb
	begin
		grant_o = '0;
		found = 1'b0;
		winner = last_q;
		cand = last_q;
		for (int k = 1; k <= 4; k++)
		begin
			cand = strand_id_t'(last_q + k);	// Wraps modulo four
			if (!found && request_i[cand])
			begin
				grant_o[cand] = 1'b1;
				winner = cand;
				found = 1'b1;
			end
		end
	end

	always_ff @(posedge clk or negedge arst_n_i)
	begin
		if (!arst_n_i)
			last_q <= strand_id_t'(3);	// Strand 0 first after reset
		else if (found)
			last_q <= winner;
	end

endmodule

`default_nettype wire

// File: rtl/strand_select_stage.sv
// Strand select stage: picks one strand per cycle and registers its issue for decode

`timescale 1ns/1ps
`default_nettype none

`include "strand_select_defines.svh"

module strand_select_stage(
	input  logic							clk,
	input  logic							arst_n_i,
	input  logic [3:0]						ma_strand_enable_i,
	input  strand_select_pkg::instr_t		if_instruction_i [4],
	input  logic							if_instruction_valid_i [4],
	input  strand_select_pkg::pc_t			if_pc_i [4],
	input  logic							rb_rollback_strand_i [4],
	input  logic							suspend_strand_i [4],
	input  logic							resume_strand_i [4],
	input  strand_select_pkg::offset_t		rollback_strided_offset_i [4],
	input  strand_select_pkg::lane_t		rollback_reg_lane_i [4],
	output logic							ss_instruction_req_o [4],
	output strand_select_pkg::pc_t			ss_pc_o,
	output strand_select_pkg::instr_t		ss_instruction_o,
	output strand_select_pkg::lane_t		ss_reg_lane_select_o,
	output strand_select_pkg::offset_t		ss_strided_offset_o,
	output strand_select_pkg::strand_id_t	ss_strand_o,
	output logic [31:0]						idle_count_o
);

	import strand_select_pkg::*;

	pc_t		fsm_pc [4];
	instr_t		fsm_instruction [4];
	lane_t		fsm_lane [4];
	offset_t	fsm_offset [4];
	logic [3:0]	fsm_request;
	logic [3:0]	execute_hazard;
	logic [3:0]	arb_request;
	logic [3:0]	grant;
	strand_id_t	sel_id;

	for (genvar i = 0; i < 4; i++)
	begin : g_strand
		strand_fsm u_strand_fsm(
			.clk						(clk),
			.arst_n_i					(arst_n_i),
			.instruction_i				(if_instruction_i[i]),
			.instruction_valid_i		(if_instruction_valid_i[i]),
			.pc_i						(if_pc_i[i]),
			.grant_i					(grant[i]),
			.flush_i					(rb_rollback_strand_i[i]),
			.suspend_strand_i			(suspend_strand_i[i]),
			.resume_strand_i			(resume_strand_i[i]),
			.rollback_strided_offset_i	(rollback_strided_offset_i[i]),
			.rollback_reg_lane_i		(rollback_reg_lane_i[i]),
			.issue_request_o			(fsm_request[i]),
			.next_instruction_o			(ss_instruction_req_o[i]),
			.pc_o						(fsm_pc[i]),
			.instruction_o				(fsm_instruction[i]),
			.reg_lane_select_o			(fsm_lane[i]),
			.strided_offset_o			(fsm_offset[i])
		);
	end

	execute_hazard_detect u_execute_hazard_detect(
		.clk				(clk),
		.arst_n_i			(arst_n_i),
		.instruction_i		(fsm_instruction),
		.grant_i			(grant),
		.execute_hazard_o	(execute_hazard)
	);

	// Disabled or hazarded strands do not compete
	assign arb_request = fsm_request & ma_strand_enable_i & ~execute_hazard;

	issue_arbiter u_issue_arbiter(
		.clk		(clk),
		.arst_n_i	(arst_n_i),
		.request_i	(arb_request),
		.grant_o	(grant)
	);

	// Grant is one-hot, encode it for the mux
	always_comb
	begin
		sel_id = '0;
		for (int i = 0; i < 4; i++)
		begin
			if (grant[i])
				sel_id = strand_id_t'(i);
		end
	end

	always_ff @(posedge clk or negedge arst_n_i)
	begin
		if (!arst_n_i)
		begin
			ss_pc_o <= '0;
			ss_instruction_o <= `NOP;
			ss_reg_lane_select_o <= '0;
			ss_strided_offset_o <= '0;
			ss_strand_o <= '0;
			idle_count_o <= '0;
		end
		else if (|grant)
		begin
			ss_pc_o <= fsm_pc[sel_id];
			ss_instruction_o <= fsm_instruction[sel_id];
			ss_reg_lane_select_o <= fsm_lane[sel_id];
			ss_strided_offset_o <= fsm_offset[sel_id];
			ss_strand_o <= sel_id;
		end
		else
		begin
			// Nothing can issue this cycle
			ss_pc_o <= '0;
			ss_instruction_o <= `NOP;
			ss_reg_lane_select_o <= '0;
			ss_strided_offset_o <= '0;
			ss_strand_o <= '0;
			idle_count_o <= idle_count_o + 32'd1;	// Idle cycle counter
		end
	end

endmodule

`default_nettype wire

// File: testbench/tb_clock_gen.sv
// Testbench clock and reset generator: free-running clock and active-low reset

`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
	parameter int CLK_PERIOD = 100,
	parameter int RESET_CYCLES = 16
)(
	output logic	clk,
	output logic	arst_n_o
);

	initial
	begin
		clk = 1'b0;
		forever
			#(CLK_PERIOD / 2) clk = ~clk;
	end

	initial
	begin
		arst_n_o <= 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		arst_n_o <= 1'b1;	// Released after the DUT samples this edge
	end

endmodule

`default_nettype wire

// File: testbench/tb_strand_select.sv
// Strand select stage testbench with random fetch and control stimulus checked by a cycle model

`timescale 1ns/1ps
`default_nettype none

`include "strand_select_defines.svh"

module tb_strand_select;

	import strand_select_pkg::*;

	localparam int NUM_CYCLES = 4000;
	localparam int RESET_CYCLES = 16;
	localparam int CLK_PERIOD = 100;

	logic			clk;
	logic			arst_n;
	logic [3:0]		enable;
	instr_t			if_instr [4];
	logic			if_valid [4];
	pc_t			if_pc [4];
	logic			rb_strand [4];
	logic			suspend [4];
	logic			resume [4];
	offset_t		rb_offset [4];
	lane_t			rb_lane [4];
	logic			ss_req [4];
	pc_t			ss_pc;
	instr_t			ss_instr;
	lane_t			ss_lane;
	offset_t		ss_offset;
	strand_id_t		ss_strand;
	logic [31:0]	idle_count;

	logic [31:0]	rng;
	strand_state_t	m_state [4];
	lane_t			m_lane [4];
	offset_t		m_offset [4];
	logic			m_adv [4];
	int				wait_count [4];
	logic [3:0]		prev_request;	// Gated requests of the cycle before
	logic [31:0]	prev_idle;
	logic [2:0]		m_hist;	// Bit 2 is the issue three cycles back
	strand_id_t		m_last;
	pc_t			m_pc;
	instr_t			m_instr;
	lane_t			m_out_lane;
	offset_t		m_out_offset;
	strand_id_t		m_strand;
	logic [31:0]	m_idle;
	int				error_count;

	tb_clock_gen #(.CLK_PERIOD(CLK_PERIOD), .RESET_CYCLES(RESET_CYCLES)) u_clock_gen(
		.clk		(clk),
		.arst_n_o	(arst_n)
	);

	strand_select_stage DUT(
		.clk						(clk),
		.arst_n_i					(arst_n),
		.ma_strand_enable_i			(enable),
		.if_instruction_i			(if_instr),
		.if_instruction_valid_i		(if_valid),
		.if_pc_i					(if_pc),
		.rb_rollback_strand_i		(rb_strand),
		.suspend_strand_i			(suspend),
		.resume_strand_i			(resume),
		.rollback_strided_offset_i	(rb_offset),
		.rollback_reg_lane_i		(rb_lane),
		.ss_instruction_req_o		(ss_req),
		.ss_pc_o					(ss_pc),
		.ss_instruction_o			(ss_instr),
		.ss_reg_lane_select_o		(ss_lane),
		.ss_strided_offset_o		(ss_offset),
		.ss_strand_o				(ss_strand),
		.idle_count_o				(idle_count)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [31:0] next_random();
		rng = xorshift32(rng);
		return rng;
	endfunction

	// Plain, long or strided, with random stride and payload bits
	function automatic instr_t random_instruction();
		logic [31:0]	r;
		logic [2:0]		op_class;
		r = next_random();
		case (r[31:30])
			2'd1: op_class = `CLASS_LONG;
			2'd2: op_class = `CLASS_STRIDED;
			default: op_class = r[29:27] % 3'd6;
		endcase
		return {op_class, r[28:0]};
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual)
		begin
			error_count++;
			$display("Fail %s expected %h actual %h", name, expected, actual);
			$display("Done: errors found");
			$fatal(1, "Stopping at the first mismatch");
		end
	endtask

	// Checks the state after the last edge, then advances the model over the next edge
	task automatic model_cycle(input int cyc);
		logic [3:0]	is_long;
		logic [3:0]	request;
		logic [3:0]	grant;
		logic		last_issue;
		logic		dut_granted;
		strand_id_t	cand;
		strand_id_t	winner;
		grant = '0;
		winner = m_last;
		for (int s = 0; s < 4; s++)
		begin
			is_long[s] = if_instr[s][`OPCLASS_HI:`OPCLASS_LO] == `CLASS_LONG;
			request[s] = m_state[s] == ST_ISSUE && if_valid[s] && enable[s]
				&& !(m_hist[2] && !is_long[s]);
		end
		for (int k = 1; k <= 4; k++)
		begin
			cand = strand_id_t'((int'(m_last) + k) % 4);
			if (grant == 4'd0 && request[cand])
			begin
				grant[cand] = 1'b1;
				winner = cand;
			end
		end
		check_value($sformatf("ss_pc cycle %0d", cyc), m_pc, ss_pc);
		check_value($sformatf("ss_instruction cycle %0d", cyc), m_instr, ss_instr);
		check_value($sformatf("ss_lane cycle %0d", cyc), 32'(m_out_lane), 32'(ss_lane));
		check_value($sformatf("ss_offset cycle %0d", cyc), m_out_offset, ss_offset);
		check_value($sformatf("ss_strand cycle %0d", cyc), 32'(m_strand), 32'(ss_strand));
		check_value($sformatf("idle_count cycle %0d", cyc), m_idle, idle_count);
		dut_granted = idle_count == prev_idle;	// DUT grant shows one cycle late
		for (int s = 0; s < 4; s++)
		begin
			last_issue = if_instr[s][`OPCLASS_HI:`OPCLASS_LO] != `CLASS_STRIDED
				|| m_lane[s] == 4'd0;
			m_adv[s] = grant[s] && !rb_strand[s] && !suspend[s] && last_issue;
			check_value($sformatf("advance strand %0d cycle %0d", s, cyc),
				32'(m_adv[s]), 32'(ss_req[s]));
			wait_count[s] = (prev_request[s] && !(dut_granted && ss_strand == strand_id_t'(s)))
				? wait_count[s] + 1 : 0;
			check_value($sformatf("rotation wait strand %0d cycle %0d", s, cyc),
				32'd1, 32'(wait_count[s] <= 3));
		end
		prev_request = request;
		prev_idle = idle_count;
		if (grant != 4'd0)
		begin
			m_pc = if_pc[winner];
			m_instr = if_instr[winner];
			m_out_lane = m_lane[winner];
			m_out_offset = m_offset[winner];
			m_strand = winner;
			m_last = winner;
		end
		else
		begin
			m_pc = '0;
			m_instr = `NOP;
			m_out_lane = '0;
			m_out_offset = '0;
			m_strand = '0;
			m_idle = m_idle + 32'd1;
		end
		m_hist = {m_hist[1:0], |(grant & is_long)};
		for (int s = 0; s < 4; s++)
		begin
			last_issue = if_instr[s][`OPCLASS_HI:`OPCLASS_LO] != `CLASS_STRIDED
				|| m_lane[s] == 4'd0;
			if (rb_strand[s])
			begin
				m_state[s] = ST_FETCH_WAIT;
				m_lane[s] = rb_lane[s];
				m_offset[s] = rb_offset[s];
			end
			else if (suspend[s])
				m_state[s] = ST_SUSPENDED;
			else if (resume[s] && m_state[s] == ST_SUSPENDED)
				m_state[s] = ST_ISSUE;
			else if (grant[s] && last_issue)
			begin
				m_state[s] = ST_FETCH_WAIT;
				m_lane[s] = 4'd15;
				m_offset[s] = '0;
			end
			else if (grant[s])
			begin
				m_lane[s] = m_lane[s] - 4'd1;
				m_offset[s] = m_offset[s] + {22'b0, if_instr[s][`STRIDE_HI:`STRIDE_LO]};
			end
			else if (m_state[s] == ST_FETCH_WAIT)
				m_state[s] = ST_ISSUE;
		end
	endtask

	task automatic drive_inputs();
		logic [31:0] r;
		for (int s = 0; s < 4; s++)
		begin
			r = next_random();
			if (m_adv[s] || rb_strand[s])	// Next or restart instruction
			begin
				if_instr[s] <= random_instruction();
				if_pc[s] <= if_pc[s] + 32'd4;
			end
			if_valid[s] <= r[3:0] != 4'd0;
			suspend[s] <= r[9:4] == 6'd0;
			resume[s] <= r[12:10] == 3'd0;
			rb_strand[s] <= r[19:13] == 7'd0;
			rb_lane[s] <= r[23:20];
			rb_offset[s] <= {24'b0, r[31:24]};
		end
		r = next_random();
		if (r[5:0] == 6'd0)
			enable <= r[9:6] | r[13:10];	// Mostly enabled
	endtask

	initial
	begin
		#((RESET_CYCLES + NUM_CYCLES + 100) * CLK_PERIOD);
		$display("Simulation hung: the watchdog timer expired before the test finished");
		$display("Done: errors found");
		$fatal(1, "Watchdog timeout");
	end

	initial
	begin
		rng = 32'd98426;
		error_count = 0;
		enable <= 4'hF;
		for (int s = 0; s < 4; s++)
		begin
			if_instr[s] <= random_instruction();
			if_valid[s] <= 1'b0;
			if_pc[s] <= 32'(s) << 12;
			rb_strand[s] <= 1'b0;
			suspend[s] <= 1'b0;
			resume[s] <= 1'b0;
			rb_offset[s] <= '0;
			rb_lane[s] <= '0;
			m_state[s] = ST_ISSUE;
			m_lane[s] = 4'd15;
			m_offset[s] = '0;
			m_adv[s] = 1'b0;
			wait_count[s] = 0;
		end
		prev_request = '0;
		prev_idle = '0;
		m_hist = '0;
		m_last = 2'd3;	// Strand 0 first after reset
		m_pc = '0;
		m_instr = `NOP;
		m_out_lane = '0;
		m_out_offset = '0;
		m_strand = '0;
		m_idle = '0;
		wait (arst_n === 1'b1);
		for (int cyc = 0; cyc < NUM_CYCLES; cyc++)
		begin
			@(negedge clk);
			model_cycle(cyc);
			@(posedge clk);
			drive_inputs();
		end
		if (error_count == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

`default_nettype wire

// File: sim.f
+incdir+rtl
rtl/strand_select_pkg.sv
rtl/strand_fsm.sv
rtl/execute_hazard_detect.sv
rtl/issue_arbiter.sv
rtl/strand_select_stage.sv
testbench/tb_clock_gen.sv
testbench/tb_strand_select.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f sim.f --top-module tb_strand_select -o tb_strand_select
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/tb_strand_select > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Done: no errors" sim.log; then
	exit 0
fi
echo "Pass message not found in sim.log"
exit 1
